// ==== Bender.yml ====
package:
  name: mxint_accum

sources:
  # design, package first
  - src/mxint_pkg.sv
  - src/mxint_block_quantizer.sv
  - src/mxint_block_fifo.sv
  - src/mxint_accumulator.sv
  - src/mxint_accum_top.sv

  # testbench
  - target: simulation
    files:
      - sim/mxint_accum_tb.sv

// ==== all.f ====
src/mxint_pkg.sv
src/mxint_block_quantizer.sv
src/mxint_block_fifo.sv
src/mxint_accumulator.sv
src/mxint_accum_top.sv
sim/mxint_accum_tb.sv

// ==== sim/mxint_accum_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mxint_accum_tb;

  localparam int CLK_HALF = 50;
  localparam int SEED = 32'h9512_12c1;
  // test lengths in groups
  localparam int B2B_GROUPS = 20;
  localparam int BP_GROUPS = 20;
  localparam int STALL_GROUPS = 3;
  localparam int NUM_GROUPS = 2 + B2B_GROUPS + BP_GROUPS + STALL_GROUPS;
  localparam int WATCHDOG_CYCLES = NUM_GROUPS * mxint_pkg::ACC_DEPTH * 40;
  // cycles of held back-pressure before release
  localparam int STALL_CYCLES = 40;
  localparam int GROUP_ELEMS = mxint_pkg::ACC_DEPTH * mxint_pkg::BLOCK_SIZE;
  // signed mantissa range
  localparam int MANT_MIN = -(1 <<< (mxint_pkg::MANT_WIDTH - 1));
  localparam int MANT_MAX = (1 <<< (mxint_pkg::MANT_WIDTH - 1)) - 1;

  logic clk;
  logic rst;
  logic signed [mxint_pkg::DATA_WIDTH-1:0]     in_data [mxint_pkg::BLOCK_SIZE];
  logic                                        in_valid;
  logic                                        in_ready;
  logic signed [mxint_pkg::EXP_WIDTH-1:0]      out_exp;
  logic signed [mxint_pkg::ACC_MANT_WIDTH-1:0] out_mant [mxint_pkg::BLOCK_SIZE];
  logic                                        out_valid;
  logic                                        out_ready;

  // 0 always ready, 1 random, 2 held low
  logic [1:0] ready_mode;

  // accepted input elements not yet forming a full group
  int pending_elems [$];
  // expected results, one exponent and BLOCK_SIZE mantissas per group
  int expected_exp [$];
  int expected_mant [$];

  int checks;
  int value_errors;
  int other_errors;

  mxint_accum_top mxint_accum_top_i (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_exp   (out_exp),
    .out_mant  (out_mant),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  task automatic check_value(input string what, input int got, input int want);
    checks++;
    if (got != want) begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
      value_errors++;
    end
  endtask

  // quantize each block, then align and sum with truncation
  function automatic void expected_sum(input int data [GROUP_ELEMS], output int sum_exp,
                                       output int sum_mant [mxint_pkg::BLOCK_SIZE]);
    int blk_exp;
    int aligned_exp;
    int v;
    bit fits;
    sum_exp = 0;
    for (int b = 0; b < mxint_pkg::ACC_DEPTH; b++) begin
      // smallest right shift where every lane fits the mantissa
      blk_exp = -1;
      for (int s = 0; s <= mxint_pkg::MAX_SHIFT; s++) begin
        if (blk_exp < 0) begin
          fits = 1'b1;
          for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
            v = data[b * mxint_pkg::BLOCK_SIZE + i] >>> s;
            if (v < MANT_MIN || v > MANT_MAX) begin
              fits = 1'b0;
            end
          end
          if (fits) begin
            blk_exp = s;
          end
        end
      end
      if (b == 0) begin
        // first block taken unshifted
        sum_exp = blk_exp;
        for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
          sum_mant[i] = data[i] >>> blk_exp;
        end
      end else begin
        // larger exponent wins, both sides shifted down to it
        aligned_exp = (blk_exp > sum_exp) ? blk_exp : sum_exp;
        for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
          v = data[b * mxint_pkg::BLOCK_SIZE + i] >>> blk_exp;
          sum_mant[i] = (sum_mant[i] >>> (aligned_exp - sum_exp)) +
                        (v >>> (aligned_exp - blk_exp));
        end
        sum_exp = aligned_exp;
      end
    end
  endfunction

  // signed value spanning the given number of bits
  function automatic int rand_elem(input int bits);
    return int'($urandom) >>> (32 - bits);
  endfunction

  // entered on a rising edge, returns on the edge of the transfer
  task automatic send_block(input int gap, input int d [mxint_pkg::BLOCK_SIZE]);
    if (gap > 0) begin
      in_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      in_data[i] <= mxint_pkg::DATA_WIDTH'(d[i]);
    end
    in_valid <= 1'b1;
    // held steady until the quantizer takes it
    do begin
      @(posedge clk);
    end while (!in_ready);
  endtask

  // per block width picked first, so exponents differ within a group
  task automatic send_random_group(input int max_bits, input int max_gap);
    int blk [mxint_pkg::BLOCK_SIZE];
    int blk_bits;
    for (int b = 0; b < mxint_pkg::ACC_DEPTH; b++) begin
      blk_bits = $urandom_range(max_bits, 3);
      for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
        blk[i] = rand_elem($urandom_range(blk_bits, 2));
      end
      send_block($urandom_range(max_gap, 0), blk);
    end
  endtask

  task automatic wait_output();
    do begin
      @(posedge clk);
    end while (!out_valid);
  endtask

  // back-pressure source
  always @(posedge clk) begin
    case (ready_mode)
      2'd1:    out_ready <= ($urandom_range(3, 0) != 0);
      2'd2:    out_ready <= 1'b0;
      default: out_ready <= 1'b1;
    endcase
  end

  // collect accepted blocks and predict each group
  always @(posedge clk) begin : watch_input
    int grp [GROUP_ELEMS];
    int e;
    int m [mxint_pkg::BLOCK_SIZE];
    if (!rst && in_valid && in_ready) begin
      for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
        pending_elems.push_back(in_data[i]);
      end
      if (pending_elems.size() == GROUP_ELEMS) begin
        for (int j = 0; j < GROUP_ELEMS; j++) begin
          grp[j] = pending_elems.pop_front();
        end
        expected_sum(grp, e, m);
        expected_exp.push_back(e);
        for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
          expected_mant.push_back(m[i]);
        end
      end
    end
  end

  // compare every output transfer against the oldest prediction
  always @(posedge clk) begin : compare_output
    int e;
    int m;
    if (!rst && out_valid && out_ready) begin
      if (expected_exp.size() == 0) begin
        $display("at %0t ns an output block arrived with no group expected", $time);
        other_errors++;
      end else begin
        e = expected_exp.pop_front();
        check_value("out_exp", out_exp, e);
        for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
          m = expected_mant.pop_front();
          check_value($sformatf("out_mant[%0d]", i), out_mant[i], m);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles with results still missing", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin : stimulus
    int blk [mxint_pkg::BLOCK_SIZE];
    int plain [mxint_pkg::BLOCK_SIZE];
    bit stalled;
    void'($urandom(SEED));
    checks = 0;
    value_errors = 0;
    other_errors = 0;
    rst = 1'b1;
    in_valid = 1'b0;
    out_ready = 1'b0;
    ready_mode = 2'd0;
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      in_data[i] = '0;
      plain[i] = 0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // idle state right after reset
    check_value("out_valid after reset", out_valid, 0);
    check_value("in_ready after reset", in_ready, 1);

    // small values, exponent 0, plain integer sum
    for (int b = 0; b < mxint_pkg::ACC_DEPTH; b++) begin
      for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
        blk[i] = rand_elem(7);
        plain[i] += blk[i];
      end
      send_block(0, blk);
    end
    in_valid <= 1'b0;
    wait_output();
    check_value("single group exponent", out_exp, 0);
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      check_value($sformatf("single group lane %0d", i), out_mant[i], plain[i]);
    end

    // exponents 0, 8, 3, 8 within one group
    blk = '{3, -5, 7, 1};
    send_block(0, blk);
    blk = '{20000, -300, 5, -1};
    send_block(0, blk);
    blk = '{1000, -1000, 17, 2};
    send_block(1, blk);
    blk = '{-32768, 0, 64, -7};
    send_block(0, blk);
    in_valid <= 1'b0;
    wait_output();
    check_value("mixed group exponent", out_exp, 8);

    // streaming with no gaps and no back-pressure
    for (int g = 0; g < B2B_GROUPS; g++) begin
      send_random_group(16, 0);
    end
    in_valid <= 1'b0;

    // random out_ready and input gaps
    ready_mode <= 2'd1;
    for (int g = 0; g < BP_GROUPS; g++) begin
      send_random_group(16, 2);
    end
    in_valid <= 1'b0;

    // hold out_ready low until the input side stalls
    ready_mode <= 2'd2;
    stalled = 1'b0;
    fork
      begin
        for (int g = 0; g < STALL_GROUPS; g++) begin
          send_random_group(16, 0);
        end
        in_valid <= 1'b0;
      end
      begin
        repeat (STALL_CYCLES) begin
          @(posedge clk);
          if (in_valid && !in_ready) begin
            stalled = 1'b1;
          end
        end
        ready_mode <= 2'd0;
      end
    join
    if (!stalled) begin
      $display("in_ready never fell while out_ready was held low");
      other_errors++;
    end

    // drain the remaining predictions
    while (expected_exp.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (pending_elems.size() != 0) begin
      $display("%0d input elements left over outside a full group", pending_elems.size());
      other_errors++;
    end

    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/mxint_accum_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mxint_accum_top (
  input  logic                                         clk,
  input  logic                                         rst,

  // fixed point blocks in
  input  logic signed [mxint_pkg::DATA_WIDTH-1:0]     in_data [mxint_pkg::BLOCK_SIZE],
  input  logic                                         in_valid,
  output logic                                         in_ready,

  // accumulated mx-int blocks out
  output logic signed [mxint_pkg::EXP_WIDTH-1:0]      out_exp,
  output logic signed [mxint_pkg::ACC_MANT_WIDTH-1:0] out_mant [mxint_pkg::BLOCK_SIZE],
  output logic                                         out_valid,
  input  logic                                         out_ready
);

  // quantizer to fifo
  logic signed [mxint_pkg::EXP_WIDTH-1:0]  q_exp;
  logic signed [mxint_pkg::MANT_WIDTH-1:0] q_mant [mxint_pkg::BLOCK_SIZE];
  logic                                    q_valid;
  logic                                    q_ready;

  // fifo to accumulator
  logic signed [mxint_pkg::EXP_WIDTH-1:0]  f_exp;
  logic signed [mxint_pkg::MANT_WIDTH-1:0] f_mant [mxint_pkg::BLOCK_SIZE];
  logic                                    f_valid;
  logic                                    f_ready;

  // producer, fixed point to mx-int
  mxint_block_quantizer mxint_block_quantizer_i (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .q_exp    (q_exp),
    .q_mant   (q_mant),
    .q_valid  (q_valid),
    .q_ready  (q_ready)
  );

  // buffer, soaks up stalls from the output side
  mxint_block_fifo mxint_block_fifo_i (
    .clk     (clk),
    .rst     (rst),
    .q_exp   (q_exp),
    .q_mant  (q_mant),
    .q_valid (q_valid),
    .q_ready (q_ready),
    .f_exp   (f_exp),
    .f_mant  (f_mant),
    .f_valid (f_valid),
    .f_ready (f_ready)
  );

  // consumer, sums ACC_DEPTH blocks per output
  mxint_accumulator mxint_accumulator_i (
    .clk       (clk),
    .rst       (rst),
    .f_exp     (f_exp),
    .f_mant    (f_mant),
    .f_valid   (f_valid),
    .f_ready   (f_ready),
    .out_exp   (out_exp),
    .out_mant  (out_mant),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// ==== src/mxint_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module mxint_accumulator (
  input  logic                                         clk,
  input  logic                                         rst,

  // mx-int blocks from the fifo
  input  logic signed [mxint_pkg::EXP_WIDTH-1:0]      f_exp,
  input  logic signed [mxint_pkg::MANT_WIDTH-1:0]     f_mant [mxint_pkg::BLOCK_SIZE],
  input  logic                                         f_valid,
  output logic                                         f_ready,

  // widened sum block
  output logic signed [mxint_pkg::EXP_WIDTH-1:0]      out_exp,
  output logic signed [mxint_pkg::ACC_MANT_WIDTH-1:0] out_mant [mxint_pkg::BLOCK_SIZE],
  output logic                                         out_valid,
  input  logic                                         out_ready
);

  // blocks taken in the current group
  logic [mxint_pkg::ACC_CNT_WIDTH-1:0] acc_cnt;

  logic take;
  logic drain;
  logic load_fresh;

  // running exponent after the incoming block is folded in
  logic signed [mxint_pkg::EXP_WIDTH-1:0] exp_max;
  // distances to exp_max, one bit wider so EXP_MIN cannot wrap
  logic signed [mxint_pkg::EXP_WIDTH:0]   shift_in;
  logic signed [mxint_pkg::EXP_WIDTH:0]   shift_acc;

  logic signed [mxint_pkg::ACC_MANT_WIDTH-1:0] in_ext     [mxint_pkg::BLOCK_SIZE];
  logic signed [mxint_pkg::ACC_MANT_WIDTH-1:0] sum_next   [mxint_pkg::BLOCK_SIZE];

  // full group waits here until taken
  assign out_valid = (acc_cnt == mxint_pkg::ACC_DEPTH);
  // a full register only frees up when the sum leaves in the same cycle
  assign f_ready   = !out_valid || out_ready;

  assign take  = f_valid && f_ready;
  assign drain = out_valid && out_ready;

  // nothing to add to, incoming block starts a group
  assign load_fresh = (acc_cnt == 0) || drain;

  // signed compare, larger exponent wins
  assign exp_max   = (out_exp > f_exp) ? out_exp : f_exp;
  assign shift_in  = exp_max - f_exp;
  assign shift_acc = exp_max - out_exp;

  // align both operands to exp_max and add lane by lane
  // truncating, shifted out bits are lost
  always_comb begin
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      in_ext[i]   = mxint_pkg::ACC_MANT_WIDTH'(f_mant[i]);
      sum_next[i] = (out_mant[i] >>> shift_acc) + (in_ext[i] >>> shift_in);
    end
  end

  // block counter
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_cnt <= '0;
    end else if (drain) begin
      // new block in the same cycle opens the next group
      acc_cnt <= take ? mxint_pkg::ACC_CNT_WIDTH'(1) : '0;
    end else if (take) begin
      acc_cnt <= acc_cnt + 1'b1;
    end
  end

  // exponent and mantissa register
  always_ff @(posedge clk) begin
    if (rst) begin
      out_exp <= mxint_pkg::EXP_MIN;
      for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
        out_mant[i] <= '0;
      end
    end else if (take) begin
      if (load_fresh) begin
        // first block of a group goes in unshifted
        out_exp <= f_exp;
        for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
          out_mant[i] <= in_ext[i];
        end
      end else begin
        out_exp <= exp_max;
        for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
          out_mant[i] <= sum_next[i];
        end
      end
    end else if (drain) begin
      // back to empty
      out_exp <= mxint_pkg::EXP_MIN;
      for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
        out_mant[i] <= '0;
      end
    end
  end

  // stalled sum holds its valid, exponent and every lane
  a_out_hold: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_exp))
  );

  for (genvar g = 0; g < mxint_pkg::BLOCK_SIZE; g++) begin : g_lane_hold
    a_mant_hold: assert property (
      @(posedge clk) disable iff (rst)
      (out_valid && !out_ready) |=> $stable(out_mant[g])
    );
  end

endmodule

`default_nettype wire

// ==== src/mxint_block_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module mxint_block_fifo (
  input  logic                                      clk,
  input  logic                                      rst,

  // write side, from the quantizer
  input  logic signed [mxint_pkg::EXP_WIDTH-1:0]   q_exp,
  input  logic signed [mxint_pkg::MANT_WIDTH-1:0]  q_mant [mxint_pkg::BLOCK_SIZE],
  input  logic                                      q_valid,
  output logic                                      q_ready,

  // read side, towards the accumulator
  output logic signed [mxint_pkg::EXP_WIDTH-1:0]   f_exp,
  output logic signed [mxint_pkg::MANT_WIDTH-1:0]  f_mant [mxint_pkg::BLOCK_SIZE],
  output logic                                      f_valid,
  input  logic                                      f_ready
);

  // block storage, exponent and mantissas side by side
  logic signed [mxint_pkg::EXP_WIDTH-1:0]  mem_exp  [mxint_pkg::FIFO_DEPTH];
  logic signed [mxint_pkg::MANT_WIDTH-1:0] mem_mant [mxint_pkg::FIFO_DEPTH][mxint_pkg::BLOCK_SIZE];

  // pointers wrap on their own, depth is a power of two
  logic [$clog2(mxint_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(mxint_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
  // occupancy, one bit more so full is representable
  logic [$clog2(mxint_pkg::FIFO_DEPTH+1)-1:0] count;

  logic wr_en;
  logic rd_en;

  // write readiness looks at full only
  assign q_ready = (count != mxint_pkg::FIFO_DEPTH);
  assign f_valid = (count != 0);

  assign wr_en = q_valid && q_ready;
  assign rd_en = f_valid && f_ready;

  // fall through, head entry always on the outputs
  always_comb begin
    f_exp = mem_exp[rd_ptr];
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      f_mant[i] = mem_mant[rd_ptr][i];
    end
  end

  // storage write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_exp[wr_ptr] <= q_exp;
      for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
        mem_mant[wr_ptr][i] <= q_mant[i];
      end
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // read and write together leave the count as is
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    count <= mxint_pkg::FIFO_DEPTH
  );

  // empty and nothing written, so nothing can be read next cycle
  a_no_empty_read: assert property (
    @(posedge clk) disable iff (rst)
    (count == 0 && !wr_en) |=> !rd_en
  );

endmodule

`default_nettype wire

// ==== src/mxint_block_quantizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mxint_block_quantizer (
  input  logic                                      clk,
  input  logic                                      rst,

  // fixed point block from outside
  input  logic signed [mxint_pkg::DATA_WIDTH-1:0]  in_data [mxint_pkg::BLOCK_SIZE],
  input  logic                                      in_valid,
  output logic                                      in_ready,

  // mx-int block towards the fifo
  output logic signed [mxint_pkg::EXP_WIDTH-1:0]   q_exp,
  output logic signed [mxint_pkg::MANT_WIDTH-1:0]  q_mant [mxint_pkg::BLOCK_SIZE],
  output logic                                      q_valid,
  input  logic                                      q_ready
);

  // shared exponent of the block at the input
  logic signed [mxint_pkg::EXP_WIDTH-1:0]  exp_sel;
  // mantissas after the shared shift
  logic signed [mxint_pkg::MANT_WIDTH-1:0] mant_next [mxint_pkg::BLOCK_SIZE];

  // search for the smallest right shift that makes the whole block fit
  // walk downwards so the last hit is the smallest one
  always_comb begin : find_shift
    logic signed [mxint_pkg::DATA_WIDTH-1:0] sh;
    logic                                    all_fit;
    // MAX_SHIFT always fits, 16 bit shifted by 8 leaves 8 bit
    exp_sel = mxint_pkg::EXP_WIDTH'(mxint_pkg::MAX_SHIFT);
    for (int s = mxint_pkg::MAX_SHIFT; s >= 0; s--) begin
      all_fit = 1'b1;
      for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
        sh = in_data[i] >>> s;
        // fits when bits above the mantissa sign are copies of it
        if (!((&sh[mxint_pkg::DATA_WIDTH-1:mxint_pkg::MANT_WIDTH-1]) ||
              !(|sh[mxint_pkg::DATA_WIDTH-1:mxint_pkg::MANT_WIDTH-1]))) begin
          all_fit = 1'b0;
        end
      end
      if (all_fit) begin
        exp_sel = mxint_pkg::EXP_WIDTH'(s);
      end
    end
  end

  // apply the chosen shift to every element
  // arithmetic shift, low bits are dropped
  always_comb begin : shift_mant
    logic signed [mxint_pkg::DATA_WIDTH-1:0] shifted;
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      shifted = in_data[i] >>> exp_sel;
      // upper bits are sign copies here, so the slice keeps the value
      mant_next[i] = shifted[mxint_pkg::MANT_WIDTH-1:0];
    end
  end

  // one output stage
  // take a new block when empty or when the held one leaves this cycle
  assign in_ready = !q_valid || q_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      q_valid <= 1'b0;
    end else if (in_ready) begin
      q_valid <= in_valid;
    end
  end

  // payload only moves on an accepted block
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      q_exp <= exp_sel;
      for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
        q_mant[i] <= mant_next[i];
      end
    end
  end

  // exponent of a held block stays in the range the search can produce
  a_exp_range: assert property (
    @(posedge clk) disable iff (rst)
    q_valid |-> (q_exp >= 0 && q_exp <= mxint_pkg::MAX_SHIFT)
  );

endmodule

`default_nettype wire

// ==== src/mxint_pkg.sv ====
`default_nettype none

package mxint_pkg;

  // input side, plain signed fixed point
  localparam int DATA_WIDTH = 16;

  // mx-int element format
  // value of one element is mant * 2**exp
  localparam int MANT_WIDTH = 8;
  localparam int EXP_WIDTH = 8;

  // elements sharing one exponent
  localparam int BLOCK_SIZE = 4;

  // blocks folded into one output block
  localparam int ACC_DEPTH = 4;

  // one extra bit so the count can reach ACC_DEPTH itself
  localparam int ACC_CNT_WIDTH = $clog2(ACC_DEPTH) + 1;

  // growth of the sum over ACC_DEPTH aligned mantissas
  // wide enough that the group sum never wraps
  localparam int ACC_MANT_WIDTH = MANT_WIDTH + $clog2(ACC_DEPTH);

  // quantizer only shifts right
  // so its exponent runs from 0 up to here
  localparam int MAX_SHIFT = DATA_WIDTH - MANT_WIDTH;

  // most negative exponent
  // marks an empty accumulator register
  localparam logic signed [EXP_WIDTH-1:0] EXP_MIN = -(2 ** (EXP_WIDTH - 1));

  // block entries held between quantizer and accumulator
  localparam int FIFO_DEPTH = 4;

endpackage

`default_nettype wire
